// File: mfp_reg_pkg.sv
// register map of the 5-bit MFP bus, APB request bundle and timer control encodings
package mfp_reg_pkg;

	// register offsets, same map as the 68901
	localparam logic [4:0] ADDR_GPIP  = 5'h00;
	localparam logic [4:0] ADDR_AER   = 5'h01;
	localparam logic [4:0] ADDR_DDR   = 5'h02;
	localparam logic [4:0] ADDR_IERA  = 5'h03;
	localparam logic [4:0] ADDR_IERB  = 5'h04;
	localparam logic [4:0] ADDR_IPRA  = 5'h05;
	localparam logic [4:0] ADDR_IPRB  = 5'h06;
	localparam logic [4:0] ADDR_ISRA  = 5'h07;
	localparam logic [4:0] ADDR_ISRB  = 5'h08;
	localparam logic [4:0] ADDR_IMRA  = 5'h09;
	localparam logic [4:0] ADDR_IMRB  = 5'h0a;
	localparam logic [4:0] ADDR_VR    = 5'h0b;
	localparam logic [4:0] ADDR_TACR  = 5'h0c;
	localparam logic [4:0] ADDR_TBCR  = 5'h0d;
	localparam logic [4:0] ADDR_TCDCR = 5'h0e;
	localparam logic [4:0] ADDR_TADR  = 5'h0f;
	localparam logic [4:0] ADDR_TBDR  = 5'h10;
	localparam logic [4:0] ADDR_TCDR  = 5'h11;
	localparam logic [4:0] ADDR_TDDR  = 5'h12;
	localparam logic [4:0] ADDR_TSR   = 5'h16;
	localparam logic [4:0] ADDR_UDR   = 5'h17;

	typedef struct packed {
		logic       psel;
		logic       penable;
		logic       pwrite;
		logic [4:0] paddr;
		logic [7:0] pwdata;
	} apb_req_t;

	// 1..7 select the delay prescaler, pulse-width modes are not implemented
	typedef enum logic [3:0] {
		TMR_STOP   = 4'd0,
		TMR_DLY4   = 4'd1,
		TMR_DLY10  = 4'd2,
		TMR_DLY16  = 4'd3,
		TMR_DLY50  = 4'd4,
		TMR_DLY64  = 4'd5,
		TMR_DLY100 = 4'd6,
		TMR_DLY200 = 4'd7,
		TMR_EVENT  = 4'd8
	} tmr_mode_t;

	// TACR/TBCR hold one mode, TCDCR packs the two 3-bit modes of C and D
	typedef union packed {
		struct packed {
			logic [3:0] rsvd;
			tmr_mode_t  mode;
		} single;
		struct packed {
			logic       rsvd_c;
			logic [2:0] mode_c;
			logic       rsvd_d;
			logic [2:0] mode_d;
		} pair;
	} tmr_ctrl_u;

endpackage

// File: mfp_irq_pkg.sv
// interrupt channel numbering and register bundles; only six of the 16 channels have sources
package mfp_irq_pkg;

	// channel numbers, higher number wins
	localparam int unsigned IRQ_TD   = 4;
	localparam int unsigned IRQ_TC   = 5;
	localparam int unsigned IRQ_ACIA = 6;
	localparam int unsigned IRQ_DMA  = 7;
	localparam int unsigned IRQ_TB   = 8;
	localparam int unsigned IRQ_TA   = 13;

	typedef struct packed {
		logic ta;
		logic tb;
		logic dma;
		logic acia;
		logic tc;
		logic td;
	} irq_src_t;

	typedef struct packed {
		logic [15:0] ier;
		logic [15:0] ipr;
		logic [15:0] isr;
		logic [15:0] imr;
	} irq_regs_t;

	typedef struct packed {
		logic [3:0] base;
		logic [3:0] chan;
	} vec_t;

endpackage

// File: mfp_timer.sv
// 8-bit MFP timer with delay and event-count modes only; the prescaler runs on clk and a data value of 0 counts 256
`timescale 1ns/10ps

module mfp_timer (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   ctrl_we_i,
	input  mfp_reg_pkg::tmr_mode_t ctrl_i,
	input  logic                   data_we_i,
	input  logic [7:0]             data_i,
	input  logic                   event_i,
	output logic [7:0]             count_o,
	output mfp_reg_pkg::tmr_mode_t mode_o,
	output logic                   done_o
);
	import mfp_reg_pkg::*;

	tmr_mode_t  mode_q;
	logic [7:0] reload_q;
	logic [7:0] count_q;
	logic [7:0] psc_q;
	logic [7:0] div;
	logic       event_d;
	logic       delay_tick;
	logic       event_tick;
	logic       tick;

	// prescaler divisor per delay mode, 0 means no prescaled tick
	function automatic logic [7:0] psc_div(tmr_mode_t m);
		case (m)
			TMR_DLY4:   return 8'd4;
			TMR_DLY10:  return 8'd10;
			TMR_DLY16:  return 8'd16;
			TMR_DLY50:  return 8'd50;
			TMR_DLY64:  return 8'd64;
			TMR_DLY100: return 8'd100;
			TMR_DLY200: return 8'd200;
			default:    return 8'd0;
		endcase
	endfunction

	assign div        = psc_div(mode_q);
	assign delay_tick = (div != 8'd0) && (psc_q == div - 8'd1);
	assign event_tick = (mode_q == TMR_EVENT) && event_i && !event_d;
	assign tick       = delay_tick || event_tick;

	assign count_o = count_q;
	assign mode_o  = mode_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			mode_q  <= TMR_STOP;
			psc_q   <= 8'd0;
			event_d <= 1'b0;
		end else begin
			event_d <= event_i;
			if (ctrl_we_i) begin
				mode_q <= ctrl_i;
				// restart the prescale period on every mode change
				psc_q  <= 8'd0;
			end else if (div == 8'd0 || delay_tick) begin
				psc_q <= 8'd0;
			end else begin
				psc_q <= psc_q + 8'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			reload_q <= 8'd0;
			count_q  <= 8'd0;
			done_o   <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (data_we_i) begin
				reload_q <= data_i;
				count_q  <= data_i;
			end else if (tick) begin
				if (count_q == 8'd1) begin
					count_q <= reload_q;
					done_o  <= 1'b1;
				end else begin
					// a count of 0 wraps to 255 here
					count_q <= count_q - 8'd1;
				end
			end
		end
	end

endmodule

// File: mfp_irq_ctrl.sv
// 16-channel MFP interrupt controller; sources are level sampled each clk and iack is a one-cycle pulse
`timescale 1ns/10ps

module mfp_irq_ctrl (
	input  logic                   clk,
	input  logic                   reset,
	input  mfp_irq_pkg::irq_src_t  src_i,
	input  logic [1:0]             ier_we_i,
	input  logic [1:0]             ipr_clr_i,
	input  logic [1:0]             isr_clr_i,
	input  logic [1:0]             imr_we_i,
	input  logic [7:0]             wdata_i,
	input  logic [4:0]             vr_i,
	input  logic                   iack_i,
	output mfp_irq_pkg::irq_regs_t regs_o,
	output logic                   irq_o,
	output mfp_irq_pkg::vec_t      vec_o
);
	import mfp_irq_pkg::*;

	irq_regs_t   regs_q;
	irq_regs_t   regs_nxt;
	logic [15:0] src_vec;
	logic [15:0] pend_map;
	logic [15:0] act_map;
	logic [3:0]  hi_pend;
	logic [3:0]  hi_act;
	logic        ack_valid;

	// index of the highest set bit, 0 for an empty map
	function automatic logic [3:0] prio16(logic [15:0] map);
		logic [3:0] idx;
		int         i;
		idx = 4'd0;
		for (i = 0; i < 16; i++) begin
			if (map[i])
				idx = i[3:0];
		end
		return idx;
	endfunction

	always_comb begin
		src_vec           = 16'h0000;
		src_vec[IRQ_TA]   = src_i.ta;
		src_vec[IRQ_TB]   = src_i.tb;
		src_vec[IRQ_DMA]  = src_i.dma;
		src_vec[IRQ_ACIA] = src_i.acia;
		src_vec[IRQ_TC]   = src_i.tc;
		src_vec[IRQ_TD]   = src_i.td;
	end

	assign pend_map  = regs_q.ipr & regs_q.imr;
	// in-service channels block lower pending channels, masked or not
	assign act_map   = pend_map | regs_q.isr;
	assign hi_pend   = prio16(pend_map);
	assign hi_act    = prio16(act_map);
	assign ack_valid = iack_i && (pend_map != 16'h0000);

	assign irq_o  = (pend_map != 16'h0000) && (hi_pend >= hi_act);
	assign regs_o = regs_q;

	always_comb begin
		int b;
		regs_nxt     = regs_q;
		regs_nxt.ipr = regs_q.ipr | (src_vec & regs_q.ier);

		if (ack_valid) begin
			regs_nxt.ipr[hi_pend] = 1'b0;
			// vr bit 3 selects software end-of-interrupt
			if (vr_i[0])
				regs_nxt.isr[hi_pend] = 1'b1;
		end

		// bus writes come last so a clear wins over a new source pulse
		for (b = 0; b < 2; b++) begin
			if (ier_we_i[b]) begin
				regs_nxt.ier[b*8 +: 8] = wdata_i;
				regs_nxt.ipr[b*8 +: 8] = regs_nxt.ipr[b*8 +: 8] & wdata_i;
			end
			if (ipr_clr_i[b])
				regs_nxt.ipr[b*8 +: 8] = regs_nxt.ipr[b*8 +: 8] & wdata_i;
			if (isr_clr_i[b])
				regs_nxt.isr[b*8 +: 8] = regs_nxt.isr[b*8 +: 8] & wdata_i;
			if (imr_we_i[b])
				regs_nxt.imr[b*8 +: 8] = wdata_i;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			regs_q <= '0;
			vec_o  <= '0;
		end else begin
			regs_q     <= regs_nxt;
			// latched every cycle so the vector is stable during the ack read
			vec_o.base <= vr_i[4:1];
			vec_o.chan <= hi_pend;
		end
	end

endmodule

// File: mfp_tx_fifo.sv
// transmit byte FIFO holding 2**FIFO_ADDR_BITS - 1 bytes; pushes while full are dropped
`timescale 1ns/10ps

module mfp_tx_fifo #(
	parameter int FIFO_ADDR_BITS = 4
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       push_i,
	input  logic [7:0] data_i,
	input  logic       strobe_i,
	output logic       full_o,
	output logic       avail_o,
	output logic [7:0] data_o
);
	localparam int DEPTH = 1 << FIFO_ADDR_BITS;

	logic [7:0]                mem [DEPTH];
	logic [FIFO_ADDR_BITS-1:0] wr_ptr;
	logic [FIFO_ADDR_BITS-1:0] rd_ptr;
	logic [FIFO_ADDR_BITS-1:0] wr_next;
	logic                      strobe_s1;
	logic                      strobe_s2;
	logic                      strobe_s3;
	logic                      pop;

	assign wr_next = wr_ptr + 1'b1;
	// one slot stays free so full and empty differ
	assign full_o  = (wr_next == rd_ptr);
	assign avail_o = (rd_ptr != wr_ptr);
	assign data_o  = mem[rd_ptr];
	assign pop     = strobe_s2 && !strobe_s3 && avail_o;

	always_ff @(posedge clk) begin
		if (push_i && !full_o)
			mem[wr_ptr] <= data_i;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			strobe_s1 <= 1'b0;
			strobe_s2 <= 1'b0;
			strobe_s3 <= 1'b0;
		end else begin
			// strobe comes from the I/O controller clock domain
			strobe_s1 <= strobe_i;
			strobe_s2 <= strobe_s1;
			strobe_s3 <= strobe_s2;
			if (push_i && !full_o)
				wr_ptr <= wr_next;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

// File: mfp_apb_regs.sv
// APB register block with zero wait states; prdata_o is valid only in a read access phase
`timescale 1ns/10ps

module mfp_apb_regs (
	input  logic                         clk,
	input  logic                         reset,
	input  mfp_reg_pkg::apb_req_t        req_i,
	output logic [7:0]                   prdata_o,
	input  logic [7:0]                   gpip_in_i,
	output logic [1:0]                   ier_we_o,
	output logic [1:0]                   ipr_clr_o,
	output logic [1:0]                   isr_clr_o,
	output logic [1:0]                   imr_we_o,
	output logic [7:0]                   wdata_o,
	output logic [4:0]                   vr_o,
	input  mfp_irq_pkg::irq_regs_t       regs_i,
	output mfp_reg_pkg::tmr_ctrl_u       tmr_ctrl_o,
	output logic [3:0]                   tmr_ctrl_we_o,
	output logic [3:0]                   tmr_data_we_o,
	input  logic [3:0][7:0]              tmr_count_i,
	input  mfp_reg_pkg::tmr_mode_t [3:0] tmr_mode_i,
	output logic                         fifo_push_o,
	input  logic                         fifo_full_i
);
	import mfp_reg_pkg::*;

	logic [7:0] gpip_q;
	logic [7:0] aer_q;
	logic [7:0] ddr_q;
	logic [7:0] vr_q;
	logic [7:0] gpip_rd;
	logic       wr_en;
	logic       rd_en;
	logic [4:0] addr;
	tmr_ctrl_u  tacr_rd;
	tmr_ctrl_u  tbcr_rd;
	tmr_ctrl_u  tcdcr_rd;

	assign addr  = req_i.paddr;
	assign wr_en = req_i.psel && req_i.penable && req_i.pwrite;
	assign rd_en = req_i.psel && req_i.penable && !req_i.pwrite;

	// byte 1 is the A register (channels 15..8), byte 0 the B register
	assign ier_we_o  = {wr_en && addr == ADDR_IERA, wr_en && addr == ADDR_IERB};
	assign ipr_clr_o = {wr_en && addr == ADDR_IPRA, wr_en && addr == ADDR_IPRB};
	assign isr_clr_o = {wr_en && addr == ADDR_ISRA, wr_en && addr == ADDR_ISRB};
	assign imr_we_o  = {wr_en && addr == ADDR_IMRA, wr_en && addr == ADDR_IMRB};
	assign wdata_o   = req_i.pwdata;
	assign vr_o      = vr_q[7:3];

	// C and D share TCDCR
	assign tmr_ctrl_o    = req_i.pwdata;
	assign tmr_ctrl_we_o = {wr_en && addr == ADDR_TCDCR, wr_en && addr == ADDR_TCDCR,
		wr_en && addr == ADDR_TBCR, wr_en && addr == ADDR_TACR};
	assign tmr_data_we_o = {wr_en && addr == ADDR_TDDR, wr_en && addr == ADDR_TCDR,
		wr_en && addr == ADDR_TBDR, wr_en && addr == ADDR_TADR};
	assign fifo_push_o   = wr_en && addr == ADDR_UDR;

	// input pins where ddr is 0, output latch where ddr is 1
	assign gpip_rd = (gpip_in_i & ~ddr_q) | (gpip_q & ddr_q);

	always_ff @(posedge clk) begin
		if (reset) begin
			gpip_q <= 8'h00;
			aer_q  <= 8'h00;
			ddr_q  <= 8'h00;
			vr_q   <= 8'h00;
		end else if (wr_en) begin
			case (addr)
				ADDR_GPIP: gpip_q <= req_i.pwdata;
				ADDR_AER:  aer_q  <= req_i.pwdata;
				ADDR_DDR:  ddr_q  <= req_i.pwdata;
				ADDR_VR:   vr_q   <= req_i.pwdata;
				default:   ;
			endcase
		end
	end

	always_comb begin
		tacr_rd              = '0;
		tacr_rd.single.mode  = tmr_mode_i[0];
		tbcr_rd              = '0;
		tbcr_rd.single.mode  = tmr_mode_i[1];
		tcdcr_rd             = '0;
		tcdcr_rd.pair.mode_c = tmr_mode_i[2][2:0];
		tcdcr_rd.pair.mode_d = tmr_mode_i[3][2:0];
	end

	always_comb begin
		prdata_o = 8'h00;
		if (rd_en) begin
			case (addr)
				ADDR_GPIP:  prdata_o = gpip_rd;
				ADDR_AER:   prdata_o = aer_q;
				ADDR_DDR:   prdata_o = ddr_q;
				ADDR_IERA:  prdata_o = regs_i.ier[15:8];
				ADDR_IERB:  prdata_o = regs_i.ier[7:0];
				ADDR_IPRA:  prdata_o = regs_i.ipr[15:8];
				ADDR_IPRB:  prdata_o = regs_i.ipr[7:0];
				ADDR_ISRA:  prdata_o = regs_i.isr[15:8];
				ADDR_ISRB:  prdata_o = regs_i.isr[7:0];
				ADDR_IMRA:  prdata_o = regs_i.imr[15:8];
				ADDR_IMRB:  prdata_o = regs_i.imr[7:0];
				ADDR_VR:    prdata_o = vr_q;
				ADDR_TACR:  prdata_o = tacr_rd;
				ADDR_TBCR:  prdata_o = tbcr_rd;
				ADDR_TCDCR: prdata_o = tcdcr_rd;
				ADDR_TADR:  prdata_o = tmr_count_i[0];
				ADDR_TBDR:  prdata_o = tmr_count_i[1];
				ADDR_TCDR:  prdata_o = tmr_count_i[2];
				ADDR_TDDR:  prdata_o = tmr_count_i[3];
				// transmit buffer empty while there is room
				ADDR_TSR:   prdata_o = fifo_full_i ? 8'h00 : 8'h80;
				default:    prdata_o = 8'h00;
			endcase
		end
	end

endmodule

// File: mfp_top.sv
// MFP subset top without UART receiver or pulse-width modes; all logic runs on the rising edge of clk
`timescale 1ns/10ps

module mfp_top #(
	parameter int FIFO_ADDR_BITS = 4
) (
	input  logic                  clk,
	input  logic                  reset,
	input  mfp_reg_pkg::apb_req_t apb_i,
	output logic [7:0]            prdata_o,
	output logic                  irq_o,
	input  logic                  iack_i,
	output mfp_irq_pkg::vec_t     vec_o,
	input  logic                  de_i,
	input  logic                  acia_i,
	input  logic                  dma_i,
	input  logic                  mono_detect_i,
	input  logic                  serial_strobe_i,
	output logic                  serial_avail_o,
	output logic [7:0]            serial_data_o
);
	import mfp_reg_pkg::*;
	import mfp_irq_pkg::*;

	logic [1:0]      ier_we;
	logic [1:0]      ipr_clr;
	logic [1:0]      isr_clr;
	logic [1:0]      imr_we;
	logic [7:0]      wdata;
	logic [4:0]      vr;
	irq_regs_t       irq_regs;
	irq_src_t        irq_src;
	tmr_ctrl_u       tmr_ctrl;
	logic [3:0]      tmr_ctrl_we;
	logic [3:0]      tmr_data_we;
	logic [3:0][7:0] tmr_count;
	tmr_mode_t [3:0] tmr_mode;
	logic [3:0]      tmr_done;
	logic            fifo_push;
	logic            fifo_full;

	assign irq_src.ta   = tmr_done[0];
	assign irq_src.tb   = tmr_done[1];
	assign irq_src.tc   = tmr_done[2];
	assign irq_src.td   = tmr_done[3];
	assign irq_src.acia = acia_i;
	assign irq_src.dma  = dma_i;

	// dma and acia lines are active high here but the port shows them active low
	mfp_apb_regs u_regs (
		.clk(clk), .reset(reset), .req_i(apb_i), .prdata_o(prdata_o),
		.gpip_in_i({mono_detect_i, 1'b0, !dma_i, !acia_i, 4'b0000}),
		.ier_we_o(ier_we), .ipr_clr_o(ipr_clr), .isr_clr_o(isr_clr), .imr_we_o(imr_we),
		.wdata_o(wdata), .vr_o(vr), .regs_i(irq_regs),
		.tmr_ctrl_o(tmr_ctrl), .tmr_ctrl_we_o(tmr_ctrl_we), .tmr_data_we_o(tmr_data_we),
		.tmr_count_i(tmr_count), .tmr_mode_i(tmr_mode),
		.fifo_push_o(fifo_push), .fifo_full_i(fifo_full)
	);

	mfp_timer u_timer_a (
		.clk(clk), .reset(reset), .ctrl_we_i(tmr_ctrl_we[0]), .ctrl_i(tmr_ctrl.single.mode),
		.data_we_i(tmr_data_we[0]), .data_i(wdata), .event_i(1'b0),
		.count_o(tmr_count[0]), .mode_o(tmr_mode[0]), .done_o(tmr_done[0])
	);

	// only timer B counts display-enable edges
	mfp_timer u_timer_b (
		.clk(clk), .reset(reset), .ctrl_we_i(tmr_ctrl_we[1]), .ctrl_i(tmr_ctrl.single.mode),
		.data_we_i(tmr_data_we[1]), .data_i(wdata), .event_i(de_i),
		.count_o(tmr_count[1]), .mode_o(tmr_mode[1]), .done_o(tmr_done[1])
	);

	mfp_timer u_timer_c (
		.clk(clk), .reset(reset), .ctrl_we_i(tmr_ctrl_we[2]),
		.ctrl_i(tmr_mode_t'({1'b0, tmr_ctrl.pair.mode_c})),
		.data_we_i(tmr_data_we[2]), .data_i(wdata), .event_i(1'b0),
		.count_o(tmr_count[2]), .mode_o(tmr_mode[2]), .done_o(tmr_done[2])
	);

	mfp_timer u_timer_d (
		.clk(clk), .reset(reset), .ctrl_we_i(tmr_ctrl_we[3]),
		.ctrl_i(tmr_mode_t'({1'b0, tmr_ctrl.pair.mode_d})),
		.data_we_i(tmr_data_we[3]), .data_i(wdata), .event_i(1'b0),
		.count_o(tmr_count[3]), .mode_o(tmr_mode[3]), .done_o(tmr_done[3])
	);

	mfp_irq_ctrl u_irq (
		.clk(clk), .reset(reset), .src_i(irq_src),
		.ier_we_i(ier_we), .ipr_clr_i(ipr_clr), .isr_clr_i(isr_clr), .imr_we_i(imr_we),
		.wdata_i(wdata), .vr_i(vr), .iack_i(iack_i),
		.regs_o(irq_regs), .irq_o(irq_o), .vec_o(vec_o)
	);

	mfp_tx_fifo #(.FIFO_ADDR_BITS(FIFO_ADDR_BITS)) u_fifo (
		.clk(clk), .reset(reset), .push_i(fifo_push), .data_i(wdata),
		.strobe_i(serial_strobe_i), .full_o(fifo_full),
		.avail_o(serial_avail_o), .data_o(serial_data_o)
	);

endmodule

// File: tb_mfp.sv
// testbench for mfp_top at the default FIFO depth; stimulus comes from a fixed-seed LFSR
`timescale 1ns/10ps

module tb_mfp;
	import mfp_reg_pkg::*;
	import mfp_irq_pkg::*;

	localparam int FIFO_ADDR_BITS = 4;
	localparam int FIFO_CAP = (1 << FIFO_ADDR_BITS) - 1;
	// two timer A periods of at most 4*64 cycles plus about 1000 cycles of bus traffic, with margin
	localparam int TIMEOUT_CYCLES = 6000;

	logic        clk;
	logic        reset;
	apb_req_t    apb;
	logic [7:0]  prdata;
	logic        irq;
	logic        iack;
	vec_t        vec;
	logic        de;
	logic        acia;
	logic        dma;
	logic        mono;
	logic        strobe;
	logic        avail;
	logic [7:0]  sdata;
	int          errors = 0;
	int          checks = 0;
	int          cycle_count;
	logic [31:0] lfsr;
	logic [7:0]  tx_expect [$];

	mfp_top #(.FIFO_ADDR_BITS(FIFO_ADDR_BITS)) u_dut (
		.clk(clk), .reset(reset), .apb_i(apb), .prdata_o(prdata),
		.irq_o(irq), .iack_i(iack), .vec_o(vec),
		.de_i(de), .acia_i(acia), .dma_i(dma), .mono_detect_i(mono),
		.serial_strobe_i(strobe), .serial_avail_o(avail), .serial_data_o(sdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// read data is zero whenever the bus is not in a read access phase
	prdata_idle_zero: assert property (@(posedge clk) disable iff (reset)
		!(apb.psel && apb.penable && !apb.pwrite) |-> (prdata == 8'h00))
		else begin
			errors++;
			$display("mismatch at %0t: prdata_o is 0x%02h outside a read access",
				$time, prdata);
		end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic next_byte(output logic [7:0] b);
		int i;
		for (i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b[i] = lfsr[0];
		end
	endtask

	task automatic check_eq(input string what, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
		end
	endtask

	task automatic apb_write(input logic [4:0] addr, input logic [7:0] data);
		@(negedge clk);
		apb.psel    = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite  = 1'b1;
		apb.paddr   = addr;
		apb.pwdata  = data;
		@(negedge clk);
		apb.penable = 1'b1;
		@(negedge clk);
		apb = '0;
	endtask

	task automatic apb_read(input logic [4:0] addr, output logic [7:0] data);
		@(negedge clk);
		apb.psel    = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite  = 1'b0;
		apb.paddr   = addr;
		apb.pwdata  = 8'h00;
		@(negedge clk);
		apb.penable = 1'b1;
		@(negedge clk);
		data = prdata;
		apb  = '0;
	endtask

	task automatic write_read_back(input logic [4:0] addr, input string name);
		logic [7:0] val;
		logic [7:0] got;
		next_byte(val);
		apb_write(addr, val);
		apb_read(addr, got);
		check_eq(name, got, val);
	endtask

	task automatic wait_irq(input int limit, input string what);
		int n;
		n = 0;
		while (!irq && n < limit) begin
			@(negedge clk);
			n++;
		end
		checks++;
		assert (irq) else begin
			errors++;
			$display("%s did not raise irq_o within %0d cycles", what, limit);
		end
	endtask

	task automatic regs_readback();
		logic [7:0] mask;
		logic [7:0] got;
		write_read_back(ADDR_IERA, "IERA");
		write_read_back(ADDR_IERB, "IERB");
		write_read_back(ADDR_IMRA, "IMRA");
		write_read_back(ADDR_IMRB, "IMRB");
		write_read_back(ADDR_VR, "VR");
		write_read_back(ADDR_DDR, "DDR");
		apb_write(ADDR_IERA, 8'h00);
		apb_write(ADDR_IMRA, 8'h00);
		// acia is channel 6, dma channel 7
		apb_write(ADDR_IERB, 8'hc0);
		@(negedge clk) acia = 1'b1;
		@(negedge clk) acia = 1'b0;
		@(negedge clk) dma = 1'b1;
		@(negedge clk) dma = 1'b0;
		apb_read(ADDR_IPRB, got);
		check_eq("IPRB after acia and dma", got, 8'hc0);
		next_byte(mask);
		apb_write(ADDR_IPRB, mask);
		apb_read(ADDR_IPRB, got);
		check_eq("IPRB after clear mask", got, 8'hc0 & mask);
		apb_write(ADDR_IERB, 8'h00);
		apb_write(ADDR_IMRB, 8'h00);
	endtask

	task automatic port_readback();
		logic [7:0] d;
		logic [7:0] g;
		logic [7:0] pins;
		logic [7:0] pat;
		logic [7:0] exp;
		logic [7:0] got;
		int         i;
		int         k;
		for (i = 0; i < 4; i++) begin
			next_byte(d);
			next_byte(g);
			// second pass flips every input pin of the first
			if (i == 1)
				pins = ~pins;
			else
				next_byte(pins);
			// first two passes show every input pin
			if (i < 2)
				d = 8'h00;
			apb_write(ADDR_DDR, d);
			apb_write(ADDR_GPIP, g);
			@(negedge clk);
			mono = pins[0];
			dma  = pins[1];
			acia = pins[2];
			pat  = {mono, 1'b0, ~dma, ~acia, 4'h0};
			for (k = 0; k < 8; k++)
				exp[k] = d[k] ? g[k] : pat[k];
			apb_read(ADDR_GPIP, got);
			check_eq("GPIP", got, exp);
		end
		@(negedge clk);
		mono = 1'b0;
		dma  = 1'b0;
		acia = 1'b0;
		apb_write(ADDR_DDR, 8'h00);
	endtask

	task automatic timer_a_delay();
		logic [7:0] rnd;
		logic [7:0] n;
		logic [7:0] got;
		next_byte(rnd);
		n = {2'b00, rnd[5:0]} + 8'd1;
		// channel 13 is bit 5 of the A registers
		apb_write(ADDR_IERA, 8'h20);
		apb_write(ADDR_IMRA, 8'h20);
		apb_write(ADDR_TACR, 8'h01);
		apb_read(ADDR_TACR, got);
		check_eq("TACR", got, 8'h01);
		apb_write(ADDR_TADR, n);
		wait_irq(4 * n + 4, "timer A first period");
		apb_read(ADDR_IPRA, got);
		check_eq("IPRA after timer A", got, 8'h20);
		apb_write(ADDR_IPRA, 8'hdf);
		wait_irq(4 * n + 4, "timer A second period");
		apb_write(ADDR_TACR, 8'h00);
		apb_write(ADDR_IERA, 8'h00);
		apb_write(ADDR_IMRA, 8'h00);
	endtask

	task automatic priority_and_ack();
		logic [7:0] rnd;
		logic [3:0] base;
		logic [7:0] m;
		logic [7:0] got;
		int         i;
		next_byte(rnd);
		base = rnd[7:4];
		m    = {5'b00000, rnd[2:0]} + 8'd1;
		// s bit set so an acknowledge marks the channel in service
		apb_write(ADDR_VR, {base, 4'b1000});
		apb_write(ADDR_IERA, 8'h21);
		apb_write(ADDR_IMRA, 8'h21);
		apb_write(ADDR_TBCR, 8'h08);
		apb_write(ADDR_TBDR, m);
		for (i = 0; i < m; i++) begin
			@(negedge clk) de = 1'b1;
			@(negedge clk) de = 1'b0;
		end
		wait_irq(4, "timer B event count");
		apb_read(ADDR_IPRA, got);
		check_eq("IPRA after de pulses", got, 8'h01);
		apb_write(ADDR_TADR, 8'd2);
		apb_write(ADDR_TACR, 8'h01);
		i   = 0;
		got = 8'h00;
		while (!got[5] && i < 20) begin
			apb_read(ADDR_IPRA, got);
			i++;
		end
		apb_write(ADDR_TACR, 8'h00);
		checks++;
		assert (got[5]) else begin
			errors++;
			$display("timer A never set its pending bit while timer B was pending");
		end
		@(negedge clk);
		check_eq("vec_o with 8 and 13 pending", vec, {base, 4'(IRQ_TA)});
		@(negedge clk) iack = 1'b1;
		@(negedge clk) iack = 1'b0;
		apb_read(ADDR_IPRA, got);
		check_eq("IPRA after iack", got, 8'h01);
		apb_read(ADDR_ISRA, got);
		check_eq("ISRA after iack", got, 8'h20);
		check_eq("irq_o while 13 in service", {7'h00, irq}, 8'h00);
		apb_write(ADDR_ISRA, 8'hdf);
		check_eq("irq_o after isr clear", {7'h00, irq}, 8'h01);
		@(negedge clk);
		check_eq("vec_o with 8 pending", vec, {base, 4'(IRQ_TB)});
		apb_write(ADDR_TBCR, 8'h00);
		apb_write(ADDR_IERA, 8'h00);
		apb_write(ADDR_IMRA, 8'h00);
	endtask

	// the pop lands three cycles after the strobe edge
	task automatic strobe_byte();
		@(negedge clk) strobe = 1'b1;
		repeat (4) @(negedge clk);
		strobe = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	task automatic drain_fifo();
		logic [7:0] exp;
		while (tx_expect.size() > 0) begin
			exp = tx_expect.pop_front();
			check_eq("serial_avail_o", {7'h00, avail}, 8'h01);
			check_eq("serial_data_o", sdata, exp);
			strobe_byte();
		end
		check_eq("serial_avail_o after drain", {7'h00, avail}, 8'h00);
	endtask

	task automatic push_bytes(input int count);
		logic [7:0] val;
		int         i;
		for (i = 0; i < count; i++) begin
			next_byte(val);
			apb_write(ADDR_UDR, val);
			tx_expect.push_back(val);
		end
	endtask

	task automatic fifo_order();
		logic [7:0] val;
		logic [7:0] got;
		push_bytes(5);
		drain_fifo();
		apb_read(ADDR_TSR, got);
		check_eq("TSR with room", got, 8'h80);
		push_bytes(FIFO_CAP);
		apb_read(ADDR_TSR, got);
		check_eq("TSR when full", got, 8'h00);
		// this byte must not come out
		next_byte(val);
		apb_write(ADDR_UDR, val);
		drain_fifo();
		apb_read(ADDR_TSR, got);
		check_eq("TSR after drain", got, 8'h80);
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		lfsr   = 32'ha205;
		reset  = 1'b1;
		apb    = '0;
		iack   = 1'b0;
		de     = 1'b0;
		acia   = 1'b0;
		dma    = 1'b0;
		mono   = 1'b0;
		strobe = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_eq("irq_o after reset", {7'h00, irq}, 8'h00);
		check_eq("serial_avail_o after reset", {7'h00, avail}, 8'h00);
		regs_readback();
		port_readback();
		timer_a_delay();
		priority_and_ack();
		fifo_order();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: all.f
mfp_reg_pkg.sv
mfp_irq_pkg.sv
mfp_timer.sv
mfp_irq_ctrl.sv
mfp_tx_fifo.sv
mfp_apb_regs.sv
mfp_top.sv
tb_mfp.sv
